// ==== hw/ex_pkg.sv ====
package ex_pkg;

  localparam int xlen = 32;
  localparam int tag_w = 4;
  localparam int unit_w = 2;

  // Entries per reservation station
  localparam int rs_depth = 2;
  localparam int rs_idx_w = $clog2(rs_depth);

  // Source tag meaning the operand value is already present
  localparam logic [tag_w-1:0] tag_invalid = '0;

  localparam logic [unit_w-1:0] unit_alu    = 2'd0;
  localparam logic [unit_w-1:0] unit_branch = 2'd1;

  typedef enum logic [3:0] {
    add    = 4'd0,
    sub    = 4'd1,
    and_op = 4'd2,
    or_op  = 4'd3,
    xor_op = 4'd4,
    sll    = 4'd5,
    srl    = 4'd6,
    slt    = 4'd7
  } alu_op_e;

  // blt and bge compare signed
  typedef enum logic [3:0] {
    beq = 4'd0,
    bne = 4'd1,
    blt = 4'd2,
    bge = 4'd3
  } br_cond_e;

  // Same dispatch word, read by the unit that receives it
  typedef union packed {
    alu_op_e  alu;
    br_cond_e br;
  } op_word_u;

endpackage : ex_pkg

// ==== hw/alu_station.sv ====
`timescale 1ns/1ns

module alu_station import ex_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             ce,
  input  logic [tag_w-1:0] target,
  input  op_word_u         op,
  input  logic [xlen-1:0]  val1,
  input  logic [xlen-1:0]  val2,
  input  logic [tag_w-1:0] tag1,
  input  logic [tag_w-1:0] tag2,
  input  logic             cdb_valid,
  input  logic [tag_w-1:0] cdb_tag,
  input  logic [xlen-1:0]  cdb_value,
  input  logic             grant,
  output logic             full,
  output logic             out_valid,
  output logic [tag_w-1:0] out_tag,
  output logic [xlen-1:0]  out_value
);

  logic             busy  [rs_depth];
  logic [xlen-1:0]  opnd1 [rs_depth];
  logic [xlen-1:0]  opnd2 [rs_depth];
  logic [tag_w-1:0] src1  [rs_depth];
  logic [tag_w-1:0] src2  [rs_depth];
  logic [tag_w-1:0] dst   [rs_depth];
  op_word_u         opw   [rs_depth];

  logic                have_free, have_ready, wr_en, iss_en;
  logic [rs_idx_w-1:0] wr_idx, iss_idx;
  logic [xlen-1:0]     in_val1, in_val2;
  logic [tag_w-1:0]    in_tag1, in_tag2;
  logic [xlen-1:0]     iss_a, iss_b, alu_res;
  logic [4:0]          shamt;

  // Lowest free slot for dispatch, lowest ready slot for issue
  always_comb begin
    have_free = 1'b0;
    have_ready = 1'b0;
    wr_idx = '0;
    iss_idx = '0;
    for (int i = rs_depth - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        have_free = 1'b1;
        wr_idx = rs_idx_w'(i);
      end
      if (busy[i] && src1[i] == tag_invalid && src2[i] == tag_invalid) begin
        have_ready = 1'b1;
        iss_idx = rs_idx_w'(i);
      end
    end
  end

  assign full = !have_free;
  assign wr_en = ce && have_free;
  assign iss_en = have_ready && (!out_valid || grant);

  // Operands arriving on the broadcast in the dispatch cycle
  always_comb begin
    in_val1 = val1;
    in_tag1 = tag1;
    in_val2 = val2;
    in_tag2 = tag2;
    if (cdb_valid && tag1 == cdb_tag) begin
      in_val1 = cdb_value;
      in_tag1 = tag_invalid;
    end
    if (cdb_valid && tag2 == cdb_tag) begin
      in_val2 = cdb_value;
      in_tag2 = tag_invalid;
    end
  end

  assign iss_a = opnd1[iss_idx];
  assign iss_b = opnd2[iss_idx];
  assign shamt = iss_b[4:0];

  always_comb begin
    case (opw[iss_idx].alu)
      add:     alu_res = iss_a + iss_b;
      sub:     alu_res = iss_a - iss_b;
      and_op:  alu_res = iss_a & iss_b;
      or_op:   alu_res = iss_a | iss_b;
      xor_op:  alu_res = iss_a ^ iss_b;
      sll:     alu_res = iss_a << shamt;
      srl:     alu_res = iss_a >> shamt;
      slt:     alu_res = {{(xlen - 1){1'b0}}, $signed(iss_a) < $signed(iss_b)};
      default: alu_res = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < rs_depth; i++) begin
        busy[i] <= 1'b0;
      end
      out_valid <= 1'b0;
    end else begin
      if (iss_en) busy[iss_idx] <= 1'b0;
      if (wr_en) busy[wr_idx] <= 1'b1;
      if (iss_en) out_valid <= 1'b1;
      else if (grant) out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < rs_depth; i++) begin
      if (wr_en && wr_idx == rs_idx_w'(i)) begin
        opnd1[i] <= in_val1;
        opnd2[i] <= in_val2;
        src1[i] <= in_tag1;
        src2[i] <= in_tag2;
        dst[i] <= target;
        opw[i] <= op;
      end else begin
        // Snoop for pending operands
        if (cdb_valid && src1[i] == cdb_tag) begin
          opnd1[i] <= cdb_value;
          src1[i] <= tag_invalid;
        end
        if (cdb_valid && src2[i] == cdb_tag) begin
          opnd2[i] <= cdb_value;
          src2[i] <= tag_invalid;
        end
      end
    end
    if (iss_en) begin
      out_tag <= dst[iss_idx];
      out_value <= alu_res;
    end
  end

  a_no_write_full: assert property (@(posedge clk) disable iff (reset) ce |-> !full);
  a_out_tag_valid: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> out_tag != tag_invalid);

endmodule : alu_station

// ==== hw/branch_station.sv ====
`timescale 1ns/1ns

module branch_station import ex_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             ce,
  input  logic [tag_w-1:0] target,
  input  op_word_u         op,
  input  logic [xlen-1:0]  val1,
  input  logic [xlen-1:0]  val2,
  input  logic [tag_w-1:0] tag1,
  input  logic [tag_w-1:0] tag2,
  input  logic [xlen-1:0]  pc_addr,
  input  logic [xlen-1:0]  offset,
  input  logic             cdb_valid,
  input  logic [tag_w-1:0] cdb_tag,
  input  logic [xlen-1:0]  cdb_value,
  input  logic             grant,
  output logic             full,
  output logic             out_valid,
  output logic [tag_w-1:0] out_tag,
  output logic [xlen-1:0]  out_value,
  output logic             out_taken
);

  logic             busy  [rs_depth];
  logic [xlen-1:0]  opnd1 [rs_depth];
  logic [xlen-1:0]  opnd2 [rs_depth];
  logic [tag_w-1:0] src1  [rs_depth];
  logic [tag_w-1:0] src2  [rs_depth];
  logic [tag_w-1:0] dst   [rs_depth];
  op_word_u         opw   [rs_depth];
  logic [xlen-1:0]  pcs   [rs_depth];
  logic [xlen-1:0]  offs  [rs_depth];

  logic                have_free, have_ready, wr_en, iss_en, taken;
  logic [rs_idx_w-1:0] wr_idx, iss_idx;
  logic [xlen-1:0]     in_val1, in_val2;
  logic [tag_w-1:0]    in_tag1, in_tag2;
  logic [xlen-1:0]     iss_a, iss_b, next_pc;

  always_comb begin
    have_free = 1'b0;
    have_ready = 1'b0;
    wr_idx = '0;
    iss_idx = '0;
    for (int i = rs_depth - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        have_free = 1'b1;
        wr_idx = rs_idx_w'(i);
      end
      if (busy[i] && src1[i] == tag_invalid && src2[i] == tag_invalid) begin
        have_ready = 1'b1;
        iss_idx = rs_idx_w'(i);
      end
    end
  end

  assign full = !have_free;
  assign wr_en = ce && have_free;
  assign iss_en = have_ready && (!out_valid || grant);

  always_comb begin
    in_val1 = val1;
    in_tag1 = tag1;
    in_val2 = val2;
    in_tag2 = tag2;
    if (cdb_valid && tag1 == cdb_tag) begin
      in_val1 = cdb_value;
      in_tag1 = tag_invalid;
    end
    if (cdb_valid && tag2 == cdb_tag) begin
      in_val2 = cdb_value;
      in_tag2 = tag_invalid;
    end
  end

  assign iss_a = opnd1[iss_idx];
  assign iss_b = opnd2[iss_idx];

  always_comb begin
    case (opw[iss_idx].br)
      beq:     taken = iss_a == iss_b;
      bne:     taken = iss_a != iss_b;
      blt:     taken = $signed(iss_a) < $signed(iss_b);
      bge:     taken = $signed(iss_a) >= $signed(iss_b);
      default: taken = 1'b0;
    endcase
  end

  // Fall through to the next sequential instruction
  assign next_pc = taken ? pcs[iss_idx] + offs[iss_idx] : pcs[iss_idx] + xlen'(4);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < rs_depth; i++) begin
        busy[i] <= 1'b0;
      end
      out_valid <= 1'b0;
    end else begin
      if (iss_en) busy[iss_idx] <= 1'b0;
      if (wr_en) busy[wr_idx] <= 1'b1;
      if (iss_en) out_valid <= 1'b1;
      else if (grant) out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < rs_depth; i++) begin
      if (wr_en && wr_idx == rs_idx_w'(i)) begin
        opnd1[i] <= in_val1;
        opnd2[i] <= in_val2;
        src1[i] <= in_tag1;
        src2[i] <= in_tag2;
        dst[i] <= target;
        opw[i] <= op;
        pcs[i] <= pc_addr;
        offs[i] <= offset;
      end else begin
        if (cdb_valid && src1[i] == cdb_tag) begin
          opnd1[i] <= cdb_value;
          src1[i] <= tag_invalid;
        end
        if (cdb_valid && src2[i] == cdb_tag) begin
          opnd2[i] <= cdb_value;
          src2[i] <= tag_invalid;
        end
      end
    end
    if (iss_en) begin
      out_tag <= dst[iss_idx];
      out_value <= next_pc;
      out_taken <= taken;
    end
  end

  a_no_write_full: assert property (@(posedge clk) disable iff (reset) ce |-> !full);

endmodule : branch_station

// ==== hw/result_bus.sv ====
`timescale 1ns/1ns

module result_bus import ex_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             alu_valid,
  input  logic [tag_w-1:0] alu_tag,
  input  logic [xlen-1:0]  alu_value,
  input  logic             branch_valid,
  input  logic [tag_w-1:0] branch_tag,
  input  logic [xlen-1:0]  branch_value,
  input  logic             branch_taken,
  output logic             alu_grant,
  output logic             branch_grant,
  output logic             cdb_valid,
  output logic [tag_w-1:0] cdb_tag,
  output logic [xlen-1:0]  cdb_value,
  output logic             cdb_taken,
  output logic             cdb_is_branch
);

  // Set when the branch station won last, so the ALU goes first after reset
  logic last_branch;

  always_comb begin
    alu_grant = alu_valid && (!branch_valid || last_branch);
    branch_grant = branch_valid && (!alu_valid || !last_branch);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cdb_valid <= 1'b0;
      last_branch <= 1'b1;
    end else begin
      cdb_valid <= alu_grant || branch_grant;
      if (alu_grant) last_branch <= 1'b0;
      else if (branch_grant) last_branch <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (alu_grant) begin
      cdb_tag <= alu_tag;
      cdb_value <= alu_value;
      cdb_taken <= 1'b0;
      cdb_is_branch <= 1'b0;
    end else if (branch_grant) begin
      cdb_tag <= branch_tag;
      cdb_value <= branch_value;
      cdb_taken <= branch_taken;
      cdb_is_branch <= 1'b1;
    end
  end

  // A losing station keeps its result until granted
  a_alu_hold: assert property (@(posedge clk) disable iff (reset)
    alu_valid && !alu_grant |=> alu_valid && $stable(alu_tag) && $stable(alu_value));
  a_branch_hold: assert property (@(posedge clk) disable iff (reset)
    branch_valid && !branch_grant |=> branch_valid && $stable(branch_tag)
      && $stable(branch_value) && $stable(branch_taken));

endmodule : result_bus

// ==== hw/ex_stage.sv ====
`timescale 1ns/1ns

module ex_stage import ex_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              ce,
  input  logic [unit_w-1:0] unit,
  input  logic [tag_w-1:0]  target,
  input  op_word_u          op,
  input  logic [xlen-1:0]   val1,
  input  logic [xlen-1:0]   val2,
  input  logic [tag_w-1:0]  tag1,
  input  logic [tag_w-1:0]  tag2,
  input  logic [xlen-1:0]   pc_addr,
  input  logic [xlen-1:0]   offset,
  output logic              full_alu,
  output logic              full_branch,
  output logic              cdb_valid,
  output logic [tag_w-1:0]  cdb_tag,
  output logic [xlen-1:0]   cdb_value,
  output logic              cdb_taken,
  output logic              cdb_is_branch
);

  logic             ce_alu, ce_branch;
  logic             alu_valid, alu_grant;
  logic [tag_w-1:0] alu_tag;
  logic [xlen-1:0]  alu_value;
  logic             branch_valid, branch_grant, branch_taken;
  logic [tag_w-1:0] branch_tag;
  logic [xlen-1:0]  branch_value;

  // Unit code picks the station that accepts this dispatch
  assign ce_alu = ce && unit == unit_alu;
  assign ce_branch = ce && unit == unit_branch;

  alu_station i_alu_station (
    .clk(clk), .reset(reset), .ce(ce_alu), .target(target), .op(op),
    .val1(val1), .val2(val2), .tag1(tag1), .tag2(tag2),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
    .grant(alu_grant), .full(full_alu),
    .out_valid(alu_valid), .out_tag(alu_tag), .out_value(alu_value)
  );

  branch_station i_branch_station (
    .clk(clk), .reset(reset), .ce(ce_branch), .target(target), .op(op),
    .val1(val1), .val2(val2), .tag1(tag1), .tag2(tag2),
    .pc_addr(pc_addr), .offset(offset),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
    .grant(branch_grant), .full(full_branch),
    .out_valid(branch_valid), .out_tag(branch_tag), .out_value(branch_value),
    .out_taken(branch_taken)
  );

  result_bus i_result_bus (
    .clk(clk), .reset(reset),
    .alu_valid(alu_valid), .alu_tag(alu_tag), .alu_value(alu_value),
    .branch_valid(branch_valid), .branch_tag(branch_tag),
    .branch_value(branch_value), .branch_taken(branch_taken),
    .alu_grant(alu_grant), .branch_grant(branch_grant),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
    .cdb_taken(cdb_taken), .cdb_is_branch(cdb_is_branch)
  );

endmodule : ex_stage

// ==== bench/ex_tests.svh ====
// Called 10 ns after a rising edge and returns at the same point of a later cycle
task automatic dispatch(input logic [unit_w-1:0] u, input logic [tag_w-1:0] t,
                        input logic [3:0] code, input logic [31:0] v1, v2,
                        input logic [tag_w-1:0] t1, t2, input logic [31:0] pc, off);
  logic [31:0] a, b;
  int waited;
  waited = 0;
  while ((u == unit_alu) ? full_alu : full_branch) begin
    @(posedge clk);
    #10;
    waited++;
    if (waited > 50) stop_with_error("Station stayed full and never accepted the dispatch");
  end
  if ((t1 != tag_invalid && !exp_valid[t1]) || (t2 != tag_invalid && !exp_valid[t2])) begin
    stop_with_error("Source tag names no instruction in flight");
  end
  a = (t1 == tag_invalid) ? v1 : exp_value[t1];
  b = (t2 == tag_invalid) ? v2 : exp_value[t2];
  predict(u, t, code, a, b, pc, off);
  ce = 1'b1;
  unit = u;
  target = t;
  op = code;
  val1 = v1;
  val2 = v2;
  tag1 = t1;
  tag2 = t2;
  pc_addr = pc;
  offset = off;
  @(posedge clk);
  #10;
  ce = 1'b0;
endtask

task automatic wait_broadcast(input logic [tag_w-1:0] t);
  int waited;
  waited = 0;
  while (!(cdb_valid && cdb_tag == t)) begin
    @(posedge clk);
    #10;
    waited++;
    if (waited > 50) stop_with_error($sformatf("Tag %0d never appeared on the result bus", t));
  end
endtask

task automatic drain();
  int cycles;
  cycles = 0;
  while (pending_tag() >= 0 && cycles < 100) begin
    @(posedge clk);
    #10;
    cycles++;
  end
  if (pending_tag() >= 0) stop_with_error($sformatf("Tag %0d was never broadcast", pending_tag()));
  // Room for a late duplicate to show up
  repeat (4) @(posedge clk);
  #10;
  clear_records();
endtask

task automatic idle_after_reset();
  repeat (8) begin
    check("full_alu", 32'(full_alu), 32'd0);
    check("full_branch", 32'(full_branch), 32'd0);
    check("cdb_valid", 32'(cdb_valid), 32'd0);
    @(posedge clk);
    #10;
  end
endtask

task automatic alu_ops();
  alu_op_e code;
  int t;
  code = code.first();
  t = 1;
  do begin
    dispatch(unit_alu, 4'(t), code, next_rand(), next_rand(), tag_invalid, tag_invalid,
             32'd0, 32'd0);
    t++;
    code = code.next();
  end while (code != code.first());
  drain();
endtask

task automatic dependency_chain();
  dispatch(unit_alu, 4'd1, add, next_rand(), next_rand(), tag_invalid, tag_invalid, 32'd0, 32'd0);
  // Sits in the station until tag 1 is broadcast
  dispatch(unit_alu, 4'd2, sub, next_rand(), next_rand(), 4'd1, tag_invalid, 32'd0, 32'd0);
  wait_broadcast(4'd1);
  // Accepted on the edge that still sees tag 1 on the broadcast
  dispatch(unit_alu, 4'd3, xor_op, next_rand(), next_rand(), 4'd1, 4'd2, 32'd0, 32'd0);
  wait_broadcast(4'd2);
  dispatch(unit_branch, 4'd4, bne, next_rand(), next_rand(), 4'd2, 4'd3,
           next_rand() & 32'hffff_fffc, next_rand());
  // Branch result used as an ALU operand
  dispatch(unit_alu, 4'd5, srl, next_rand(), next_rand(), 4'd4, tag_invalid, 32'd0, 32'd0);
  drain();
endtask

task automatic branch_conditions();
  br_cond_e cond;
  logic [31:0] base, a, b;
  int t;
  cond = cond.first();
  t = 1;
  do begin
    // Equal, less and greater signed operands
    for (int rel = 0; rel < 3; rel++) begin
      base = (next_rand() >> 2) | 32'd1;
      a = (rel == 1) ? -base : base;
      b = (rel == 2) ? -base : base;
      dispatch(unit_branch, 4'(t), cond, a, b, tag_invalid, tag_invalid,
               next_rand() & 32'hffff_fffc, next_rand());
      t++;
    end
    cond = cond.next();
  end while (cond != cond.first());
  drain();
endtask

task automatic back_pressure();
  logic [31:0] pa, pb;
  pa = next_rand();
  pb = next_rand();
  // Producer result known up front so the waiters can name tag 1
  predict(unit_alu, 4'd1, add, pa, pb, 32'd0, 32'd0);
  dispatch(unit_branch, 4'd2, blt, next_rand(), next_rand(), 4'd1, tag_invalid,
           next_rand() & 32'hffff_fffc, next_rand());
  check("full_branch", 32'(full_branch), 32'd0);
  dispatch(unit_branch, 4'd3, beq, next_rand(), next_rand(), tag_invalid, 4'd1,
           next_rand() & 32'hffff_fffc, next_rand());
  check("full_branch", 32'(full_branch), 32'd1);
  dispatch(unit_alu, 4'd4, sll, next_rand(), next_rand(), 4'd1, 4'd1, 32'd0, 32'd0);
  check("full_alu", 32'(full_alu), 32'd0);
  dispatch(unit_alu, 4'd1, add, pa, pb, tag_invalid, tag_invalid, 32'd0, 32'd0);
  check("full_alu", 32'(full_alu), 32'd1);
  check("full_branch", 32'(full_branch), 32'd1);
  drain();
endtask

// ==== bench/tb_ex_stage.sv ====
`timescale 1ns/1ns

module tb_ex_stage import ex_pkg::*; ();

  localparam int n_tags = 1 << tag_w;
  localparam int n_dispatch = 30;
  localparam int watchdog_cycles = 16 + n_dispatch * 20 + 100;

  logic              clk, reset, ce;
  logic [unit_w-1:0] unit;
  logic [tag_w-1:0]  target, tag1, tag2, cdb_tag;
  logic [3:0]        op;
  logic [xlen-1:0]   val1, val2, pc_addr, offset, cdb_value;
  logic              full_alu, full_branch, cdb_valid, cdb_taken, cdb_is_branch;

  logic [31:0] lcg_state = 32'h75c32b4c;

  // Expected broadcast per destination tag
  logic        exp_valid  [n_tags];
  logic        seen       [n_tags];
  logic        exp_branch [n_tags];
  logic        exp_taken  [n_tags];
  logic [31:0] exp_value  [n_tags];

  ex_stage i_ex_stage (
    .clk(clk), .reset(reset), .ce(ce), .unit(unit), .target(target), .op(op),
    .val1(val1), .val2(val2), .tag1(tag1), .tag2(tag2),
    .pc_addr(pc_addr), .offset(offset),
    .full_alu(full_alu), .full_branch(full_branch),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
    .cdb_taken(cdb_taken), .cdb_is_branch(cdb_is_branch)
  );

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      stop_with_error($sformatf("Mismatch %s: got %h, expected %h", name, got, want));
    end
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] alu_model(input alu_op_e code, input logic [31:0] a, b);
    case (code)
      add:     return a + b;
      sub:     return a - b;
      and_op:  return a & b;
      or_op:   return a | b;
      xor_op:  return a ^ b;
      sll:     return a << b[4:0];
      srl:     return a >> b[4:0];
      slt:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: return 32'd0;
    endcase
  endfunction

  function automatic logic branch_model(input br_cond_e cond, input logic [31:0] a, b);
    case (cond)
      beq:     return a == b;
      bne:     return a != b;
      blt:     return $signed(a) < $signed(b);
      bge:     return $signed(a) >= $signed(b);
      default: return 1'b0;
    endcase
  endfunction

  task automatic predict(input logic [unit_w-1:0] u, input logic [tag_w-1:0] t,
                         input logic [3:0] code, input logic [31:0] a, b, pc, off);
    exp_valid[t] = 1'b1;
    seen[t] = 1'b0;
    exp_branch[t] = (u == unit_branch);
    exp_taken[t] = 1'b0;
    if (u == unit_branch) begin
      exp_taken[t] = branch_model(br_cond_e'(code), a, b);
      exp_value[t] = exp_taken[t] ? pc + off : pc + 32'd4;
    end else begin
      exp_value[t] = alu_model(alu_op_e'(code), a, b);
    end
  endtask

  task automatic clear_records();
    for (int i = 0; i < n_tags; i++) begin
      exp_valid[i] = 1'b0;
      seen[i] = 1'b0;
      exp_branch[i] = 1'b0;
      exp_taken[i] = 1'b0;
      exp_value[i] = 32'd0;
    end
  endtask

  // Lowest tag still waiting for its broadcast, or -1
  function automatic int pending_tag();
    for (int i = 0; i < n_tags; i++) begin
      if (exp_valid[i] && !seen[i]) return i;
    end
    return -1;
  endfunction

  `include "ex_tests.svh"

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    stop_with_error("Watchdog timeout, the tests did not finish in time");
  end

  // Broadcast monitor
  always @(negedge clk) begin
    if (!reset && cdb_valid === 1'b1) begin
      if (!exp_valid[cdb_tag]) begin
        stop_with_error($sformatf("Tag %0d broadcast with no instruction in flight", cdb_tag));
      end
      if (seen[cdb_tag]) begin
        stop_with_error($sformatf("Tag %0d broadcast twice", cdb_tag));
      end
      check("cdb_value", cdb_value, exp_value[cdb_tag]);
      check("cdb_is_branch", 32'(cdb_is_branch), 32'(exp_branch[cdb_tag]));
      if (exp_branch[cdb_tag]) check("cdb_taken", 32'(cdb_taken), 32'(exp_taken[cdb_tag]));
      seen[cdb_tag] = 1'b1;
    end
  end

  initial begin
    reset = 1'b1;
    ce = 1'b0;
    unit = unit_alu;
    target = '0;
    op = '0;
    val1 = '0;
    val2 = '0;
    tag1 = '0;
    tag2 = '0;
    pc_addr = '0;
    offset = '0;
    clear_records();
    repeat (16) @(posedge clk);
    #10;
    reset = 1'b0;
    idle_after_reset();
    alu_ops();
    dependency_chain();
    branch_conditions();
    back_pressure();
    $display("All checks passed");
    $finish;
  end

endmodule : tb_ex_stage

// ==== vlog.f ====
+incdir+bench
hw/ex_pkg.sv
hw/alu_station.sv
hw/branch_station.sv
hw/result_bus.sv
hw/ex_stage.sv
bench/tb_ex_stage.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ex_stage -f vlog.f

# A failing check ends in $fatal, which gives a non-zero exit status
./obj_dir/Vtb_ex_stage
